/* cpu.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/forward.sv
rtl/stage_if.sv
rtl/stage_id.sv
rtl/stage_ex.sv
rtl/stage_mem.sv
rtl/cpu.sv
sim/cpu_assert.sv
sim/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_pkg.sv
      - rtl/forward.sv
      - rtl/stage_if.sv
      - rtl/stage_id.sv
      - rtl/stage_ex.sv
      - rtl/stage_mem.sv
      - rtl/cpu.sv

  - target: simulation
    files:
      - sim/cpu_assert.sv
      - sim/tb_cpu.sv

/* sim/tb_cpu.sv */
// testbench with clock, reset, instruction ROM program, reference model, checks and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int ROM_WORDS = 128;
	localparam int T_RESET = 0;
	localparam int T_ALU = 1;
	localparam int T_WT = 2;
	localparam int T_MEM = 3;
	localparam int T_BR = 4;

	logic clk;
	logic rst_n;
	logic [31:0] instrmem_addr;
	logic [31:0] instrmem_data;
	logic [31:0] debug_out;

	instr_t rom [ROM_WORDS];
	bit exp_check [ROM_WORDS];
	logic [31:0] exp_value [ROM_WORDS];
	int exp_test [ROM_WORDS];
	logic [31:0] mreg [32]; // model register file
	logic [31:0] mmem [`DMEM_WORDS];
	string test_name [5] = '{"reset", "alu_forward", "write_through_r0", "load_store", "branch"};
	int test_total [5];
	int test_done [5];
	int test_errors [5];
	int prog_len = 0;
	int cur_test;
	int check_total = 0;
	int checks_left;
	int error_count = 0;
	bit prog_ready = 1'b0;
	logic [31:0] hist [$];
	logic [31:0] fetched;

	cpu i_dut (.clk(clk), .rst_n(rst_n), .instrmem_addr(instrmem_addr),
		.instrmem_data(instrmem_data), .debug_out(debug_out));

	// past the program the ROM reads as nop
	assign instrmem_data = (instrmem_addr < 4 * prog_len) ? rom[instrmem_addr[8:2]] : '0;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic instr_t encode_r(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		instr_t w;
		w.r = '{OP_RTYPE, rs, rt, rd, shamt, funct};
		return w;
	endfunction

	function automatic instr_t encode_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		instr_t w;
		w.i = '{op, rs, rt, imm};
		return w;
	endfunction

	function automatic logic [15:0] rand_imm();
		return 16'($urandom());
	endfunction

	task automatic place_word(input instr_t w, input logic [4:0] dest, input logic [31:0] value);
		rom[prog_len] = w;
		if (dest != 5'd0)
			mreg[dest] = value;
		if (dest == `DEBUG_REG) begin
			exp_check[prog_len] = 1'b1;
			exp_value[prog_len] = value;
			exp_test[prog_len] = cur_test;
			test_total[cur_test]++;
		end
		prog_len++;
	endtask

	task automatic rtype(input logic [5:0] funct, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] shamt);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		a = mreg[rs];
		b = mreg[rt];
		case (funct)
			FN_ADDU: r = a + b;
			FN_SUBU: r = a - b;
			FN_AND: r = a & b;
			FN_OR: r = a | b;
			FN_XOR: r = a ^ b;
			FN_SLT: r = {31'b0, $signed(a) < $signed(b)};
			default: r = b << shamt; // sll
		endcase
		place_word(encode_r(funct, rd, rs, rt, shamt), rd, r);
	endtask

	task automatic itype(input logic [5:0] op, input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		logic [31:0] ea;
		logic [31:0] r;
		logic [4:0] dest;
		ea = mreg[rs] + {{16{imm[15]}}, imm};
		r = '0;
		dest = rt;
		case (op)
			OP_ANDI: r = mreg[rs] & {16'h0, imm};
			OP_ORI: r = mreg[rs] | {16'h0, imm};
			OP_LUI: r = {imm, 16'h0};
			OP_LW: r = mmem[ea[7:2]];
			OP_SW: begin
				mmem[ea[7:2]] = mreg[rt];
				dest = 5'd0;
			end
			OP_BEQ, OP_BNE: dest = 5'd0; // program layout decides taken or not
			default: r = ea; // addiu
		endcase
		place_word(encode_i(op, rt, rs, imm), dest, r);
	endtask

	// word that a taken branch jumps over and that would spoil r1
	task automatic skip_slot();
		rom[prog_len] = encode_i(OP_ADDIU, 5'd1, 5'd0, 16'h7777);
		prog_len++;
	endtask

	task automatic check_value(input int t, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: expected %h, actual %h", test_name[t], expected, actual);
			test_errors[t]++;
			error_count++;
		end
		test_done[t]++;
		checks_left--;
		if (test_done[t] == test_total[t])
			$display("test %s finished: %0d checks, %0d errors", test_name[t],
				test_done[t], test_errors[t]);
	endtask

	task automatic build_program();
		logic [15:0] off1;
		logic [15:0] off2;
		test_total[T_RESET] = 8;
		cur_test = T_ALU;
		itype(OP_ADDIU, 1, 0, rand_imm());
		rtype(FN_ADDU, 1, 1, 1, 0);
		itype(OP_ORI, 2, 0, rand_imm());
		rtype(FN_SUBU, 1, 1, 2, 0);
		rtype(FN_XOR, 1, 1, 2, 0);
		rtype(FN_OR, 1, 1, 2, 0);
		itype(OP_ANDI, 1, 1, rand_imm());
		rtype(FN_SLL, 1, 0, 1, 5'd5);
		itype(OP_LUI, 1, 0, rand_imm());
		rtype(FN_SLT, 1, 2, 1, 0);
		rtype(FN_AND, 1, 1, 2, 0);
		itype(OP_ADDIU, 1, 1, 16'hffff);
		cur_test = T_WT;
		itype(OP_ADDIU, 3, 0, rand_imm());
		itype(OP_ADDIU, 4, 0, rand_imm());
		rtype(FN_ADDU, 1, 3, 0, 0); // r3 two back
		itype(OP_ORI, 5, 0, rand_imm());
		rtype(FN_SUBU, 1, 4, 1, 0);
		itype(OP_ADDIU, 0, 0, rand_imm());
		rtype(FN_ADDU, 1, 0, 0, 0);
		itype(OP_ORI, 0, 3, rand_imm());
		itype(OP_ADDIU, 6, 0, 16'd1);
		rtype(FN_ADDU, 1, 0, 3, 0);
		cur_test = T_MEM;
		off1 = rand_imm() & 16'h00fc;
		off2 = rand_imm() & 16'h00fc;
		itype(OP_LUI, 7, 0, rand_imm());
		itype(OP_ORI, 7, 7, rand_imm());
		itype(OP_SW, 7, 0, off1);
		itype(OP_ADDIU, 8, 0, rand_imm());
		itype(OP_SW, 8, 0, off2);
		itype(OP_LW, 1, 0, off1);
		itype(OP_ADDIU, 9, 0, 16'd1); // load gap
		itype(OP_LW, 1, 0, off2);
		itype(OP_ADDIU, 9, 9, 16'd1);
		rtype(FN_ADDU, 1, 1, 7, 0);
		cur_test = T_BR;
		itype(OP_ORI, 2, 0, rand_imm() | 16'h1);
		itype(OP_BEQ, 2, 2, 16'd3);
		itype(OP_ADDIU, 1, 0, rand_imm());
		rtype(FN_ADDU, 1, 1, 2, 0);
		skip_slot();
		itype(OP_ADDIU, 1, 1, 16'd1);
		itype(OP_BNE, 2, 2, 16'd3); // falls through
		rtype(FN_XOR, 1, 1, 2, 0);
		itype(OP_ADDIU, 1, 1, rand_imm());
		itype(OP_ORI, 1, 1, rand_imm() | 16'h1);
		itype(OP_BNE, 0, 1, 16'd3); // r1 is odd
		itype(OP_ADDIU, 1, 1, 16'd1);
		rtype(FN_SLL, 1, 0, 1, 5'd1);
		skip_slot();
		rtype(FN_SUBU, 1, 1, 2, 0);
		itype(OP_BEQ, 0, 2, 16'd3);
		rtype(FN_OR, 1, 1, 2, 0);
		itype(OP_ADDIU, 1, 1, rand_imm());
	endtask

	// word fetched in cycle k is visible on debug_out in cycle k+4
	always @(negedge clk) begin
		if (rst_n) begin
			hist.push_front(instrmem_addr);
			if (hist.size() > 4) begin
				fetched = hist.pop_back();
				if (fetched < 4 * prog_len && exp_check[fetched[8:2]])
					check_value(exp_test[fetched[8:2]], exp_value[fetched[8:2]], debug_out);
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		void'($urandom(55781));
		for (int i = 0; i < 32; i++)
			mreg[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			mmem[i] = '0;
		build_program();
		foreach (test_total[t])
			check_total += test_total[t];
		checks_left = check_total;
		prog_ready = 1'b1;
		repeat (8) begin
			@(negedge clk);
			check_value(T_RESET, `RESET_PC, instrmem_addr);
		end
		@(posedge clk);
		#5 rst_n = 1'b1;
		wait (checks_left == 0);
		repeat (2) @(posedge clk);
		$display("%0d checks, %0d value errors, %0d assertion failures", check_total,
			error_count, i_dut.uassert.error_count);
		if (error_count == 0 && i_dut.uassert.error_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		wait (prog_ready);
		#((prog_len + 20) * CLK_PERIOD);
		$display("watchdog expired before every check was reached");
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/cpu_assert.sv */
// concurrent assertions on reset fetch, sequential fetch and branch redirect, bound to cpu
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_assert (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [`WORD_WIDTH-1:0] instrmem_addr,
	input wire logic [`WORD_WIDTH-1:0] instrmem_data,
	input wire logic do_branch
);
	import cpu_pkg::*;

	int error_count = 0; // failed assertions so far

	instr_t fetch_word;
	logic fetch_branch;
	logic [`WORD_WIDTH-1:0] fetch_offset;

	assign fetch_word = instrmem_data;
	assign fetch_branch = (fetch_word.i.opcode == OP_BEQ) || (fetch_word.i.opcode == OP_BNE);
	// byte distance from the slot after the branch
	assign fetch_offset = {{(`WORD_WIDTH-18){fetch_word.i.imm[15]}}, fetch_word.i.imm, 2'b00};

	reset_hold: assert property (@(posedge clk) !rst_n |=> instrmem_addr == `RESET_PC)
		else begin
			error_count++;
			$error("fetch address was not the reset value during or right after reset");
		end

	// plain fetch steps one word
	seq_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		!do_branch |=> instrmem_addr == $past(instrmem_addr) + 4)
		else begin
			error_count++;
			$error("fetch address did not advance by one word");
		end

	// branch fetched in cycle k resolves in k+2 and steers fetch in k+3
	branch_taken: assert property (@(posedge clk) disable iff (!rst_n)
		$past(fetch_branch, 2) && do_branch |=>
			instrmem_addr == $past(instrmem_addr, 3) + 4 + $past(fetch_offset, 3))
		else begin
			error_count++;
			$error("taken branch did not redirect fetch to its destination");
		end

	branch_not_taken: assert property (@(posedge clk) disable iff (!rst_n)
		$past(fetch_branch, 2) && !do_branch |=>
			instrmem_addr == $past(instrmem_addr, 3) + 12)
		else begin
			error_count++;
			$error("branch not taken but fetch did not continue at branch pc + 12");
		end

endmodule

bind cpu cpu_assert uassert (.clk(clk), .rst_n(rst_n), .instrmem_addr(instrmem_addr),
	.instrmem_data(instrmem_data), .do_branch(do_branch));

`default_nettype wire

/* rtl/cpu.sv */
// top level with the four pipeline stages and two forwarding units
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module cpu (
	input wire logic clk,
	input wire logic rst_n,

	output logic [`WORD_WIDTH-1:0] instrmem_addr,
	input wire logic [`WORD_WIDTH-1:0] instrmem_data,

	output logic [`WORD_WIDTH-1:0] debug_out
);
	import cpu_pkg::*;

	instr_t if_instr;
	logic [`WORD_WIDTH-1:0] if_pc;

	alu_op_e id_alu_op;
	wb_src_e id_wb_src;
	branch_e id_branch;
	logic id_mem_write;
	logic [`WORD_WIDTH-1:0] id_reg1_data;
	logic [`WORD_WIDTH-1:0] id_reg2_data;
	logic [`WORD_WIDTH-1:0] id_imm;
	logic id_use_imm;
	logic [4:0] id_shamt;
	logic [`WORD_WIDTH-1:0] id_pc;
	logic [`REGADDR_WIDTH-1:0] id_wb_addr;
	logic [`REGADDR_WIDTH-1:0] id_reg1_addr;
	logic [`REGADDR_WIDTH-1:0] id_reg2_addr;

	logic [`WORD_WIDTH-1:0] ex_alu_result;
	logic [`WORD_WIDTH-1:0] ex_store_data;
	logic ex_mem_write;
	wb_src_e ex_wb_src;
	logic [`REGADDR_WIDTH-1:0] ex_wb_addr;

	logic reg1_forward;
	logic reg2_forward;
	logic [`WORD_WIDTH-1:0] reg1_forward_data;
	logic [`WORD_WIDTH-1:0] reg2_forward_data;

	logic wb_enable;
	logic [`REGADDR_WIDTH-1:0] wb_addr;
	logic [`WORD_WIDTH-1:0] wb_data;

	logic do_branch;
	logic [`WORD_WIDTH-1:0] branch_dest;

	forward ufwd1 (.alu_opr_reg_addr(id_reg1_addr), .ex2mem_alu_result(ex_alu_result),
		.ex2mem_wb_reg_addr(ex_wb_addr), .ex2mem_wb_src(ex_wb_src),
		.forward_enable(reg1_forward), .forward_data(reg1_forward_data));
	forward ufwd2 (.alu_opr_reg_addr(id_reg2_addr), .ex2mem_alu_result(ex_alu_result),
		.ex2mem_wb_reg_addr(ex_wb_addr), .ex2mem_wb_src(ex_wb_src),
		.forward_enable(reg2_forward), .forward_data(reg2_forward_data));

	stage_if uif (.clk(clk), .rst_n(rst_n),
		.do_branch(do_branch), .branch_dest(branch_dest),
		.mem_addr(instrmem_addr), .mem_data(instrmem_data),
		.if_instr(if_instr), .if_pc(if_pc));

	stage_id uid (.clk(clk), .rst_n(rst_n), .if_instr(if_instr), .if_pc(if_pc),
		.wb_enable(wb_enable), .wb_addr(wb_addr), .wb_data(wb_data),
		.reg1_addr(id_reg1_addr), .reg2_addr(id_reg2_addr),
		.id_alu_op(id_alu_op), .id_wb_src(id_wb_src), .id_branch(id_branch),
		.id_mem_write(id_mem_write), .id_reg1_data(id_reg1_data),
		.id_reg2_data(id_reg2_data), .id_imm(id_imm), .id_use_imm(id_use_imm),
		.id_shamt(id_shamt), .id_pc(id_pc), .id_wb_addr(id_wb_addr),
		.debug_out(debug_out));

	stage_ex uex (.clk(clk), .rst_n(rst_n),
		.id_alu_op(id_alu_op), .id_wb_src(id_wb_src), .id_branch(id_branch),
		.id_mem_write(id_mem_write), .id_reg1_data(id_reg1_data),
		.id_reg2_data(id_reg2_data), .id_imm(id_imm), .id_use_imm(id_use_imm),
		.id_shamt(id_shamt), .id_pc(id_pc), .id_wb_addr(id_wb_addr),
		.reg1_forward(reg1_forward), .reg1_forward_data(reg1_forward_data),
		.reg2_forward(reg2_forward), .reg2_forward_data(reg2_forward_data),
		.do_branch(do_branch), .branch_dest(branch_dest),
		.ex_alu_result(ex_alu_result), .ex_store_data(ex_store_data),
		.ex_mem_write(ex_mem_write), .ex_wb_src(ex_wb_src), .ex_wb_addr(ex_wb_addr));

	stage_mem umem (.clk(clk), .rst_n(rst_n),
		.ex_alu_result(ex_alu_result), .ex_store_data(ex_store_data),
		.ex_mem_write(ex_mem_write), .ex_wb_src(ex_wb_src), .ex_wb_addr(ex_wb_addr),
		.wb_enable(wb_enable), .wb_addr(wb_addr), .wb_data(wb_data));

endmodule

`default_nettype wire

/* rtl/stage_mem.sv */
// memory stage with data RAM, load/store and writeback select
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module stage_mem (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic [`WORD_WIDTH-1:0] ex_alu_result,
	input wire logic [`WORD_WIDTH-1:0] ex_store_data,
	input wire logic ex_mem_write,
	input wire cpu_pkg::wb_src_e ex_wb_src,
	input wire logic [`REGADDR_WIDTH-1:0] ex_wb_addr,

	output logic wb_enable,
	output logic [`REGADDR_WIDTH-1:0] wb_addr,
	output logic [`WORD_WIDTH-1:0] wb_data
);
	import cpu_pkg::*;

	localparam int DMEM_AW = $clog2(`DMEM_WORDS);

	logic [`WORD_WIDTH-1:0] dmem [`DMEM_WORDS];
	logic [DMEM_AW-1:0] word_addr;

	assign word_addr = ex_alu_result[DMEM_AW+1:2]; // byte address to word index

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (ex_mem_write) begin
			dmem[word_addr] <= ex_store_data;
		end
	end

	// register file takes these on the next edge
	assign wb_enable = (ex_wb_src != WB_NONE);
	assign wb_addr = ex_wb_addr;
	assign wb_data = (ex_wb_src == WB_MEM) ? dmem[word_addr] : ex_alu_result;

endmodule

`default_nettype wire

/* rtl/stage_ex.sv */
// execute stage with operand select, ALU, branch resolve and execute/memory register
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module stage_ex (
	input wire logic clk,
	input wire logic rst_n,

	input wire cpu_pkg::alu_op_e id_alu_op,
	input wire cpu_pkg::wb_src_e id_wb_src,
	input wire cpu_pkg::branch_e id_branch,
	input wire logic id_mem_write,
	input wire logic [`WORD_WIDTH-1:0] id_reg1_data,
	input wire logic [`WORD_WIDTH-1:0] id_reg2_data,
	input wire logic [`WORD_WIDTH-1:0] id_imm,
	input wire logic id_use_imm,
	input wire logic [4:0] id_shamt,
	input wire logic [`WORD_WIDTH-1:0] id_pc,
	input wire logic [`REGADDR_WIDTH-1:0] id_wb_addr,

	input wire logic reg1_forward,
	input wire logic [`WORD_WIDTH-1:0] reg1_forward_data,
	input wire logic reg2_forward,
	input wire logic [`WORD_WIDTH-1:0] reg2_forward_data,

	output logic do_branch,
	output logic [`WORD_WIDTH-1:0] branch_dest,

	output logic [`WORD_WIDTH-1:0] ex_alu_result,
	output logic [`WORD_WIDTH-1:0] ex_store_data,
	output logic ex_mem_write,
	output cpu_pkg::wb_src_e ex_wb_src,
	output logic [`REGADDR_WIDTH-1:0] ex_wb_addr
);
	import cpu_pkg::*;

	logic [`WORD_WIDTH-1:0] opr1;
	logic [`WORD_WIDTH-1:0] opr2; // rt, also store data
	logic [`WORD_WIDTH-1:0] alu_b;
	logic [`WORD_WIDTH-1:0] alu_result;

	assign opr1 = reg1_forward ? reg1_forward_data : id_reg1_data;
	assign opr2 = reg2_forward ? reg2_forward_data : id_reg2_data;
	assign alu_b = id_use_imm ? id_imm : opr2;

	always_comb begin
		case (id_alu_op)
			ALU_ADD: alu_result = opr1 + alu_b;
			ALU_SUB: alu_result = opr1 - alu_b;
			ALU_AND: alu_result = opr1 & alu_b;
			ALU_OR: alu_result = opr1 | alu_b;
			ALU_XOR: alu_result = opr1 ^ alu_b;
			ALU_SLT: alu_result = {{(`WORD_WIDTH-1){1'b0}}, $signed(opr1) < $signed(alu_b)};
			ALU_SLL: alu_result = alu_b << id_shamt;
			ALU_LUI: alu_result = {alu_b[15:0], {(`WORD_WIDTH-16){1'b0}}};
			default: alu_result = '0;
		endcase
	end

	always_comb begin
		case (id_branch)
			BR_EQ: do_branch = (opr1 == opr2);
			BR_NE: do_branch = (opr1 != opr2);
			default: do_branch = 1'b0;
		endcase
	end

	// word offset relative to the slot after the branch
	assign branch_dest = id_pc + `WORD_WIDTH'd4 + {id_imm[`WORD_WIDTH-3:0], 2'b00};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_write <= 1'b0;
			ex_wb_src <= WB_NONE;
		end else begin
			ex_mem_write <= id_mem_write;
			ex_wb_src <= id_wb_src;
		end
	end

	always_ff @(posedge clk) begin
		ex_alu_result <= alu_result;
		ex_store_data <= opr2;
		ex_wb_addr <= id_wb_addr;
	end

endmodule

`default_nettype wire

/* rtl/stage_id.sv */
// decode stage with control decode, register file and decode/execute register
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module stage_id (
	input wire logic clk,
	input wire logic rst_n,
	input wire cpu_pkg::instr_t if_instr,
	input wire logic [`WORD_WIDTH-1:0] if_pc,

	input wire logic wb_enable,
	input wire logic [`REGADDR_WIDTH-1:0] wb_addr,
	input wire logic [`WORD_WIDTH-1:0] wb_data,

	output logic [`REGADDR_WIDTH-1:0] reg1_addr,
	output logic [`REGADDR_WIDTH-1:0] reg2_addr,

	output cpu_pkg::alu_op_e id_alu_op,
	output cpu_pkg::wb_src_e id_wb_src,
	output cpu_pkg::branch_e id_branch,
	output logic id_mem_write,
	output logic [`WORD_WIDTH-1:0] id_reg1_data,
	output logic [`WORD_WIDTH-1:0] id_reg2_data,
	output logic [`WORD_WIDTH-1:0] id_imm,
	output logic id_use_imm,
	output logic [4:0] id_shamt,
	output logic [`WORD_WIDTH-1:0] id_pc,
	output logic [`REGADDR_WIDTH-1:0] id_wb_addr,

	output logic [`WORD_WIDTH-1:0] debug_out
);
	import cpu_pkg::*;

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	alu_op_e alu_op;
	wb_src_e wb_src;
	branch_e branch;
	logic mem_write;
	logic use_imm;
	logic zero_ext;
	logic [`REGADDR_WIDTH-1:0] dest;
	logic [`WORD_WIDTH-1:0] imm;
	logic [`WORD_WIDTH-1:0] rdata1;
	logic [`WORD_WIDTH-1:0] rdata2;

	always_comb begin
		alu_op = ALU_ADD;
		wb_src = WB_NONE;
		branch = BR_NONE;
		mem_write = 1'b0;
		use_imm = 1'b1;
		zero_ext = 1'b0;
		dest = if_instr.i.rt;
		case (if_instr.r.opcode)
			OP_RTYPE: begin
				use_imm = 1'b0;
				dest = if_instr.r.rd;
				wb_src = WB_ALU;
				case (if_instr.r.funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR: alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL: alu_op = ALU_SLL;
					default: wb_src = WB_NONE; // unknown funct
				endcase
			end
			OP_ADDIU: wb_src = WB_ALU;
			OP_ANDI: begin
				alu_op = ALU_AND;
				zero_ext = 1'b1;
				wb_src = WB_ALU;
			end
			OP_ORI: begin
				alu_op = ALU_OR;
				zero_ext = 1'b1;
				wb_src = WB_ALU;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				wb_src = WB_ALU;
			end
			OP_LW: wb_src = WB_MEM;
			OP_SW: mem_write = 1'b1;
			OP_BEQ: begin
				branch = BR_EQ;
				use_imm = 1'b0;
			end
			OP_BNE: begin
				branch = BR_NE;
				use_imm = 1'b0;
			end
			default: ;
		endcase
		// writes to r0 turn into bubbles
		if (dest == '0)
			wb_src = WB_NONE;
	end

	assign imm = zero_ext ? {{(`WORD_WIDTH-16){1'b0}}, if_instr.i.imm} :
		{{(`WORD_WIDTH-16){if_instr.i.imm[15]}}, if_instr.i.imm};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_enable && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// write-through read, r0 tied to zero
	function automatic logic [`WORD_WIDTH-1:0] read_reg(
		input logic [`REGADDR_WIDTH-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb_enable && wb_addr == addr)
			return wb_data;
		return regs[addr];
	endfunction

	always_comb begin
		rdata1 = read_reg(if_instr.r.rs);
		rdata2 = read_reg(if_instr.r.rt);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_alu_op <= ALU_ADD;
			id_wb_src <= WB_NONE;
			id_branch <= BR_NONE;
			id_mem_write <= 1'b0;
		end else begin
			id_alu_op <= alu_op;
			id_wb_src <= wb_src;
			id_branch <= branch;
			id_mem_write <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		id_reg1_data <= rdata1;
		id_reg2_data <= rdata2;
		id_imm <= imm;
		id_use_imm <= use_imm;
		id_shamt <= if_instr.r.shamt;
		id_pc <= if_pc;
		id_wb_addr <= dest;
		reg1_addr <= if_instr.r.rs;
		reg2_addr <= if_instr.r.rt;
	end

	assign debug_out = regs[`DEBUG_REG];

endmodule

`default_nettype wire

/* rtl/stage_if.sv */
// fetch stage with program counter, branch redirect and fetch register
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module stage_if (
	input wire logic clk,
	input wire logic rst_n,

	input wire logic do_branch,
	input wire logic [`WORD_WIDTH-1:0] branch_dest,

	output logic [`WORD_WIDTH-1:0] mem_addr,
	input wire logic [`WORD_WIDTH-1:0] mem_data,

	output cpu_pkg::instr_t if_instr,
	output logic [`WORD_WIDTH-1:0] if_pc
);
	logic [`WORD_WIDTH-1:0] pc;
	logic [`WORD_WIDTH-1:0] pc_next;

	// no flush, so the two words behind a branch still run
	assign pc_next = do_branch ? branch_dest : pc + `WORD_WIDTH'd4;
	assign mem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `RESET_PC;
			if_instr <= '0; // sll r0 is a nop
			if_pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
			if_instr <= mem_data;
			if_pc <= pc;
		end
	end

endmodule

`default_nettype wire

/* rtl/forward.sv */
// forwarding decision for one execute operand
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module forward (
	input wire logic [`REGADDR_WIDTH-1:0] alu_opr_reg_addr,
	input wire logic [`WORD_WIDTH-1:0] ex2mem_alu_result,
	input wire logic [`REGADDR_WIDTH-1:0] ex2mem_wb_reg_addr,
	input wire cpu_pkg::wb_src_e ex2mem_wb_src,
	output logic forward_enable,
	output logic [`WORD_WIDTH-1:0] forward_data
);
	import cpu_pkg::*;

	logic addr_match;

	assign addr_match = (alu_opr_reg_addr == ex2mem_wb_reg_addr);

	// r0 never forwards, loads are not ready yet
	assign forward_enable = addr_match && (alu_opr_reg_addr != '0) &&
		(ex2mem_wb_src == WB_ALU);

	assign forward_data = ex2mem_alu_result;

endmodule

`default_nettype wire

/* rtl/cpu_pkg.sv */
// instruction formats and union, opcode and funct codes, ALU/writeback/branch selectors
`default_nettype none

package cpu_pkg;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} i_fmt_t;

	// same word, register or immediate view
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM} wb_src_e;

	typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_e;

endpackage

`default_nettype wire

/* rtl/cpu_defs.svh */
// word and register address widths, register count, data RAM depth, debug register, reset PC
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path
`define WORD_WIDTH 32

// register file
`define REGADDR_WIDTH 5
`define REG_COUNT 32

// data RAM in words, addressed by bits 7:2
`define DMEM_WORDS 64

// register shown on debug_out
`define DEBUG_REG 1

// first fetch address
`define RESET_PC 32'h0000_0000

`endif
